//--- rtl/mem_exec_pkg.sv
package mem_exec_pkg;

    // datapath and page geometry
    localparam int XLEN      = 32;
    localparam int PAGE_BITS = 12;
    localparam int VPN_BITS  = 20;

    typedef enum logic [3:0] {
        MEM_NONE,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        LWL,
        LWR,
        SB,
        SH,
        SW,
        SWL,
        SWR
    } mem_op_e;

    // translation query machine
    typedef enum logic [1:0] {
        Q_IDLE,
        Q_QUERY,
        Q_REQ
    } qstate_e;

    // cp0 cause codes for memory exceptions
    localparam logic [4:0] EXC_MOD  = 5'd1;
    localparam logic [4:0] EXC_TLBL = 5'd2;
    localparam logic [4:0] EXC_TLBS = 5'd3;
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_ADES = 5'd5;

    // data bus size field
    localparam logic [2:0] SIZE_BYTE = 3'd0;
    localparam logic [2:0] SIZE_HALF = 3'd1;
    localparam logic [2:0] SIZE_WORD = 3'd2;

endpackage

//--- rtl/xlat_if.sv
interface xlat_if
    import mem_exec_pkg::*;
();

    // query machine side
    logic                fill;
    logic                flush;
    logic [XLEN-1:0]     vaddr_save;

    // cached translation
    logic                hit;
    logic [VPN_BITS-1:0] paddr_hi;
    logic                miss;
    logic                invalid;
    logic                dirty;
    logic [2:0]          cattr;

    modport fsm (
        output fill,
        output flush,
        output vaddr_save,
        input  hit
    );

    modport cache (
        input  fill,
        input  flush,
        input  vaddr_save,
        output hit,
        output paddr_hi,
        output miss,
        output invalid,
        output dirty,
        output cattr
    );

endinterface

//--- rtl/mem_addr_gen.sv
module mem_addr_gen
    import mem_exec_pkg::*;
(
    input  mem_op_e          op_i,
    input  logic [XLEN-1:0]  base_i,
    input  logic [15:0]      offset_i,
    input  logic [XLEN-1:0]  wdata_i,
    input  logic             user_mode_i,
    output logic [XLEN-1:0]  eaddr_o,
    output logic             unmapped_o,
    output logic             kseg0_o,
    output logic             is_load_o,
    output logic             is_store_o,
    output logic             addr_err_o,
    output logic [4:0]       err_code_o,
    output logic [3:0]       wstrb_o,
    output logic [XLEN-1:0]  wdata_o,
    output logic [2:0]       size_o
);

    logic [1:0] boff;
    logic [1:0] boffn;
    logic       misaligned;
    logic       kseg_user;

    assign eaddr_o = base_i + {{16{offset_i[15]}}, offset_i};
    assign boff    = eaddr_o[1:0];
    assign boffn   = ~boff;

    // kseg0 and kseg1 bypass translation
    assign unmapped_o = eaddr_o[31:30] == 2'b10;
    assign kseg0_o    = eaddr_o[31:29] == 3'b100;

    assign is_load_o  = op_i inside {LB, LH, LW, LBU, LHU, LWL, LWR};
    assign is_store_o = op_i inside {SB, SH, SW, SWL, SWR};

    assign misaligned = ((op_i == LW || op_i == SW) && boff != 2'd0)
                     || ((op_i == LH || op_i == LHU || op_i == SH) && boff[0]);
    assign kseg_user  = user_mode_i && eaddr_o[31];

    assign addr_err_o = (is_load_o || is_store_o) && (misaligned || kseg_user);
    assign err_code_o = is_store_o ? EXC_ADES : EXC_ADEL;

    always_comb begin
        wstrb_o = 4'b0000;
        wdata_o = '0;
        case (op_i)
            SB: begin
                wstrb_o = 4'b0001 << boff;
                wdata_o = {4{wdata_i[7:0]}};
            end
            SH: begin
                wstrb_o = 4'b0011 << boff;
                wdata_o = {2{wdata_i[15:0]}};
            end
            SW: begin
                wstrb_o = 4'b1111;
                wdata_o = wdata_i;
            end
            // unaligned word stores shift toward the addressed lanes
            SWL: begin
                wstrb_o = 4'b1111 >> boffn;
                wdata_o = wdata_i >> (8 * boffn);
            end
            SWR: begin
                wstrb_o = 4'b1111 << boff;
                wdata_o = wdata_i << (8 * boff);
            end
            default: ;
        endcase
    end

    always_comb begin
        case (op_i)
            LW, LWL, LWR, SW, SWL, SWR: size_o = SIZE_WORD;
            LH, LHU, SH:                size_o = SIZE_HALF;
            default:                    size_o = SIZE_BYTE;
        endcase
    end

    load_store_excl: assert final ($onehot0({is_load_o, is_store_o}))
        else $error("load and store decoded together");

endmodule

//--- rtl/tlb_query_fsm.sv
module tlb_query_fsm
    import mem_exec_pkg::*;
(
    input  logic             clk,
    input  logic             resetn,
    input  logic             valid_i,
    input  logic             need_xlat_i,
    input  logic [XLEN-1:0]  eaddr_i,
    input  logic             data_addr_ok_i,
    input  logic             tlb_exc_i,
    input  logic             tlb_flush_i,
    output qstate_e          qstate_o,
    output logic [XLEN-1:0]  tlb_vaddr_o,
    xlat_if.fsm              xi
);

    qstate_e         state;
    qstate_e         state_next;
    logic            start;
    logic [XLEN-1:0] vaddr_save;

    // mapped access that the cached entry cannot serve
    assign start = valid_i && need_xlat_i && !xi.hit;

    always_comb begin
        case (state)
            Q_IDLE:  state_next = start ? Q_QUERY : Q_IDLE;
            Q_QUERY: state_next = Q_REQ;
            Q_REQ:   state_next = (tlb_exc_i || data_addr_ok_i) ? Q_IDLE : Q_REQ;
            default: state_next = Q_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= Q_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == Q_IDLE && start) begin
            vaddr_save <= eaddr_i;
        end
    end

    assign qstate_o      = state;
    assign tlb_vaddr_o   = vaddr_save;
    assign xi.vaddr_save = vaddr_save;
    assign xi.fill       = state == Q_QUERY;
    assign xi.flush      = tlb_flush_i;

    query_one_cycle: assert property (
        @(posedge clk) disable iff (!resetn)
        state == Q_QUERY |=> state == Q_REQ
    );

    req_after_query: assert property (
        @(posedge clk) disable iff (!resetn)
        (state == Q_REQ && $past(state) != Q_REQ) |-> $past(state) == Q_QUERY
    );

endmodule

//--- rtl/xlat_cache.sv
module xlat_cache
    import mem_exec_pkg::*;
(
    input  logic             clk,
    input  logic             resetn,
    xlat_if.cache            xi,
    input  logic [XLEN-1:0]  tlb_paddr_i,
    input  logic             tlb_miss_i,
    input  logic             tlb_invalid_i,
    input  logic             tlb_dirty_i,
    input  logic [2:0]       tlb_cattr_i,
    input  logic [XLEN-1:0]  eaddr_i,
    input  logic             is_store_i,
    output logic             tlb_exc_o,
    output logic [4:0]       tlb_code_o
);

    logic                valid;
    logic [VPN_BITS-1:0] vpn;
    logic [VPN_BITS-1:0] ppn;
    logic                miss_q;
    logic                invalid_q;
    logic                dirty_q;
    logic [2:0]          cattr_q;
    logic                no_entry;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (xi.flush) begin
            valid <= 1'b0;
        end else if (xi.fill) begin
            valid <= 1'b1;
        end
    end

    // tlb result is sampled in the query cycle
    always_ff @(posedge clk) begin
        if (xi.fill) begin
            vpn       <= xi.vaddr_save[XLEN-1:PAGE_BITS];
            ppn       <= tlb_paddr_i[XLEN-1:PAGE_BITS];
            miss_q    <= tlb_miss_i;
            invalid_q <= tlb_invalid_i;
            dirty_q   <= tlb_dirty_i;
            cattr_q   <= tlb_cattr_i;
        end
    end

    assign xi.hit      = valid && (vpn == eaddr_i[XLEN-1:PAGE_BITS]);
    assign xi.paddr_hi = ppn;
    assign xi.miss     = miss_q;
    assign xi.invalid  = invalid_q;
    assign xi.dirty    = dirty_q;
    assign xi.cattr    = cattr_q;

    assign no_entry  = xi.miss || xi.invalid;
    assign tlb_exc_o = xi.hit && (no_entry || (is_store_i && !xi.dirty));

    always_comb begin
        if (!is_store_i) begin
            tlb_code_o = EXC_TLBL;
        end else if (no_entry) begin
            tlb_code_o = EXC_TLBS;
        end else begin
            // clean page written
            tlb_code_o = EXC_MOD;
        end
    end

endmodule

//--- rtl/mem_req_ctrl.sv
module mem_req_ctrl
    import mem_exec_pkg::*;
(
    input  logic                 valid_i,
    input  qstate_e              qstate_i,
    input  logic [XLEN-1:0]      eaddr_i,
    input  logic                 unmapped_i,
    input  logic                 kseg0_i,
    input  logic                 is_load_i,
    input  logic                 is_store_i,
    input  logic                 addr_err_i,
    input  logic [4:0]           err_code_i,
    input  logic                 hit_i,
    input  logic [VPN_BITS-1:0]  paddr_hi_i,
    input  logic                 miss_i,
    input  logic [2:0]           cattr_i,
    input  logic                 tlb_exc_i,
    input  logic [4:0]           tlb_code_i,
    input  logic [2:0]           config_k0_i,
    input  logic                 data_addr_ok_i,
    output logic                 data_req_o,
    output logic                 data_wr_o,
    output logic                 data_cache_o,
    output logic [XLEN-1:0]      data_addr_o,
    output logic                 done_o,
    output logic                 exc_o,
    output logic [4:0]           exccode_o,
    output logic [XLEN-1:0]      badvaddr_o,
    output logic                 tlb_refill_o,
    output logic                 load_stall_o,
    output logic                 store_stall_o
);

    logic access;
    logic direct_ok;
    logic xlat_ok;
    logic addr_exc;
    logic tlb_exc;

    assign access    = valid_i && (is_load_i || is_store_i);
    assign direct_ok = qstate_i == Q_IDLE && unmapped_i;
    // a cached translation is usable on a hit or after a refill
    assign xlat_ok   = (qstate_i == Q_IDLE && !unmapped_i && hit_i) || qstate_i == Q_REQ;

    assign addr_exc = access && addr_err_i && qstate_i == Q_IDLE;
    assign tlb_exc  = access && !addr_err_i && xlat_ok && tlb_exc_i;

    assign data_req_o = access && !addr_err_i && (direct_ok || (xlat_ok && !tlb_exc_i));
    assign data_wr_o  = is_store_i;

    assign data_addr_o  = direct_ok ? {3'b000, eaddr_i[28:0]}
                                    : {paddr_hi_i, eaddr_i[PAGE_BITS-1:0]};
    assign data_cache_o = unmapped_i ? (kseg0_i && config_k0_i[0]) : cattr_i[0];

    assign exc_o        = addr_exc || tlb_exc;
    assign exccode_o    = addr_exc ? err_code_i : tlb_code_i;
    assign badvaddr_o   = eaddr_i;
    assign tlb_refill_o = tlb_exc && miss_i;
    assign done_o       = exc_o || (data_req_o && data_addr_ok_i);

    // request pending but not yet taken
    assign load_stall_o  = data_req_o && !data_addr_ok_i && is_load_i;
    assign store_stall_o = data_req_o && !data_addr_ok_i && is_store_i;

    req_exc_excl: assert final (!(data_req_o && exc_o))
        else $error("request issued with an exception");

endmodule

//--- rtl/wait_cycle_counter.sv
module wait_cycle_counter (
    input  logic        clk,
    input  logic        resetn,
    input  logic        inc_i,
    output logic [31:0] count_o
);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count_o <= 32'd0;
        end else if (inc_i) begin
            count_o <= count_o + 32'd1;
        end
    end

endmodule

//--- rtl/mem_exec_top.sv
module mem_exec_top
    import mem_exec_pkg::*;
(
    input  logic             clk,
    input  logic             resetn,
    input  logic             valid_i,
    input  mem_op_e          op_i,
    input  logic [XLEN-1:0]  base_i,
    input  logic [15:0]      offset_i,
    input  logic [XLEN-1:0]  wdata_i,
    input  logic             user_mode_i,
    input  logic [2:0]       config_k0_i,
    input  logic             tlb_flush_i,
    input  logic [XLEN-1:0]  tlb_paddr_i,
    input  logic             tlb_miss_i,
    input  logic             tlb_invalid_i,
    input  logic             tlb_dirty_i,
    input  logic [2:0]       tlb_cattr_i,
    input  logic             data_addr_ok_i,
    output logic             data_req_o,
    output logic             data_wr_o,
    output logic             data_cache_o,
    output logic [3:0]       data_wstrb_o,
    output logic [XLEN-1:0]  data_addr_o,
    output logic [2:0]       data_size_o,
    output logic [XLEN-1:0]  data_wdata_o,
    output logic [XLEN-1:0]  tlb_vaddr_o,
    output logic             done_o,
    output logic             exc_o,
    output logic [4:0]       exccode_o,
    output logic [XLEN-1:0]  badvaddr_o,
    output logic             tlb_refill_o,
    output logic [31:0]      load_wait_cnt_o,
    output logic [31:0]      store_wait_cnt_o
);

    logic [XLEN-1:0] eaddr;
    logic            unmapped;
    logic            kseg0;
    logic            is_load;
    logic            is_store;
    logic            addr_err;
    logic [4:0]      err_code;
    logic            need_xlat;
    qstate_e         qstate;
    logic            tlb_exc;
    logic [4:0]      tlb_code;
    logic            load_stall;
    logic            store_stall;

    xlat_if u_xlat ();

    // only clean mapped accesses go to the tlb
    assign need_xlat = (is_load || is_store) && !unmapped && !addr_err;

    mem_addr_gen u_addr_gen (
        .op_i        (op_i),
        .base_i      (base_i),
        .offset_i    (offset_i),
        .wdata_i     (wdata_i),
        .user_mode_i (user_mode_i),
        .eaddr_o     (eaddr),
        .unmapped_o  (unmapped),
        .kseg0_o     (kseg0),
        .is_load_o   (is_load),
        .is_store_o  (is_store),
        .addr_err_o  (addr_err),
        .err_code_o  (err_code),
        .wstrb_o     (data_wstrb_o),
        .wdata_o     (data_wdata_o),
        .size_o      (data_size_o)
    );

    tlb_query_fsm u_query (
        .clk            (clk),
        .resetn         (resetn),
        .valid_i        (valid_i),
        .need_xlat_i    (need_xlat),
        .eaddr_i        (eaddr),
        .data_addr_ok_i (data_addr_ok_i),
        .tlb_exc_i      (tlb_exc),
        .tlb_flush_i    (tlb_flush_i),
        .qstate_o       (qstate),
        .tlb_vaddr_o    (tlb_vaddr_o),
        .xi             (u_xlat)
    );

    xlat_cache u_cache (
        .clk           (clk),
        .resetn        (resetn),
        .xi            (u_xlat),
        .tlb_paddr_i   (tlb_paddr_i),
        .tlb_miss_i    (tlb_miss_i),
        .tlb_invalid_i (tlb_invalid_i),
        .tlb_dirty_i   (tlb_dirty_i),
        .tlb_cattr_i   (tlb_cattr_i),
        .eaddr_i       (eaddr),
        .is_store_i    (is_store),
        .tlb_exc_o     (tlb_exc),
        .tlb_code_o    (tlb_code)
    );

    mem_req_ctrl u_req (
        .valid_i        (valid_i),
        .qstate_i       (qstate),
        .eaddr_i        (eaddr),
        .unmapped_i     (unmapped),
        .kseg0_i        (kseg0),
        .is_load_i      (is_load),
        .is_store_i     (is_store),
        .addr_err_i     (addr_err),
        .err_code_i     (err_code),
        .hit_i          (u_xlat.hit),
        .paddr_hi_i     (u_xlat.paddr_hi),
        .miss_i         (u_xlat.miss),
        .cattr_i        (u_xlat.cattr),
        .tlb_exc_i      (tlb_exc),
        .tlb_code_i     (tlb_code),
        .config_k0_i    (config_k0_i),
        .data_addr_ok_i (data_addr_ok_i),
        .data_req_o     (data_req_o),
        .data_wr_o      (data_wr_o),
        .data_cache_o   (data_cache_o),
        .data_addr_o    (data_addr_o),
        .done_o         (done_o),
        .exc_o          (exc_o),
        .exccode_o      (exccode_o),
        .badvaddr_o     (badvaddr_o),
        .tlb_refill_o   (tlb_refill_o),
        .load_stall_o   (load_stall),
        .store_stall_o  (store_stall)
    );

    wait_cycle_counter u_load_wait (
        .clk     (clk),
        .resetn  (resetn),
        .inc_i   (load_stall),
        .count_o (load_wait_cnt_o)
    );

    wait_cycle_counter u_store_wait (
        .clk     (clk),
        .resetn  (resetn),
        .inc_i   (store_stall),
        .count_o (store_wait_cnt_o)
    );

endmodule

//--- tests/mem_exec_tb.sv
module mem_exec_tb
    import mem_exec_pkg::*;
();

    localparam logic [19:0] PPN_XOR      = 20'h5A5A5;
    localparam int          NUM_ACCESSES = 72;
    localparam int          MAX_CYCLES   = 40 * NUM_ACCESSES + 200;

    logic clk;
    logic resetn;
    logic valid_i, user_mode_i, tlb_flush_i, data_addr_ok_i;
    mem_op_e op_i;
    logic [31:0] base_i, wdata_i, tlb_paddr_i;
    logic [15:0] offset_i;
    logic [2:0]  config_k0_i, tlb_cattr_i;
    logic tlb_miss_i, tlb_invalid_i, tlb_dirty_i;
    logic data_req_o, data_wr_o, data_cache_o, done_o, exc_o, tlb_refill_o;
    logic [3:0]  data_wstrb_o;
    logic [2:0]  data_size_o;
    logic [4:0]  exccode_o;
    logic [31:0] data_addr_o, data_wdata_o, tlb_vaddr_o, badvaddr_o;
    logic [31:0] load_wait_cnt_o, store_wait_cnt_o;

    // expected response for the current cycle
    logic        exp_req, exp_exc, exp_query, exp_wr, exp_cache, exp_refill;
    logic [31:0] exp_addr, exp_eaddr, exp_wdata;
    logic [3:0]  exp_wstrb;
    logic [2:0]  exp_size;
    logic [4:0]  exp_code;
    int          exp_load_wait, exp_store_wait;

    logic        xc_valid;
    logic [19:0] xc_vpn;
    logic [31:0] rng_state;
    int          err_count, err_mark, test_count, cycle_count;

    mem_exec_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // tlb model, combinational on the query address
    always_comb begin
        tlb_paddr_i   = '0;
        tlb_miss_i    = 1'b0;
        tlb_invalid_i = 1'b0;
        tlb_dirty_i   = 1'b0;
        tlb_cattr_i   = 3'd0;
        if (!$isunknown(tlb_vaddr_o)) begin
            tlb_paddr_i = {tlb_vaddr_o[31:12] ^ PPN_XOR, 12'h000};
            case (tlb_vaddr_o[15:12])
                4'hF: tlb_miss_i = 1'b1;
                4'hE: tlb_invalid_i = 1'b1;
                4'hD: tlb_cattr_i = 3'd3;
                default: begin
                    tlb_dirty_i = 1'b1;
                    tlb_cattr_i = 3'd3;
                end
            endcase
        end
    end

    task automatic report_mismatch(input string msg);
        err_count++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    req_check: assert property (@(posedge clk) disable iff (!resetn) data_req_o == exp_req)
        else report_mismatch($sformatf("data_req_o is %0b", $sampled(data_req_o)));
    addr_check: assert property (@(posedge clk) disable iff (!resetn)
        exp_req |-> data_addr_o == exp_addr && data_cache_o == exp_cache && data_wr_o == exp_wr)
        else report_mismatch($sformatf("request addr %h cache %0b, expected %h cache %0b",
            $sampled(data_addr_o), $sampled(data_cache_o), exp_addr, exp_cache));
    fmt_check: assert property (@(posedge clk) disable iff (!resetn)
        exp_req |-> data_size_o == exp_size
            && (!exp_wr || (data_wstrb_o == exp_wstrb && data_wdata_o == exp_wdata)))
        else report_mismatch($sformatf("store format strb %b data %h size %0d",
            $sampled(data_wstrb_o), $sampled(data_wdata_o), $sampled(data_size_o)));
    exc_check: assert property (@(posedge clk) disable iff (!resetn) exc_o == exp_exc)
        else report_mismatch($sformatf("exc_o is %0b", $sampled(exc_o)));
    code_check: assert property (@(posedge clk) disable iff (!resetn)
        exp_exc |-> exccode_o == exp_code && badvaddr_o == exp_eaddr
            && tlb_refill_o == exp_refill)
        else report_mismatch($sformatf("exception code %0d badvaddr %h refill %0b",
            $sampled(exccode_o), $sampled(badvaddr_o), $sampled(tlb_refill_o)));
    done_check: assert property (@(posedge clk) disable iff (!resetn)
        done_o == (exp_exc || (exp_req && data_addr_ok_i)))
        else report_mismatch($sformatf("done_o is %0b", $sampled(done_o)));
    query_check: assert property (@(posedge clk) disable iff (!resetn)
        exp_query |-> tlb_vaddr_o == exp_eaddr)
        else report_mismatch($sformatf("tlb_vaddr_o is %h", $sampled(tlb_vaddr_o)));
    stable_check: assert property (@(posedge clk) disable iff (!resetn)
        data_req_o && !data_addr_ok_i |=> data_req_o && $stable(data_addr_o)
            && $stable(data_wdata_o) && $stable(data_wstrb_o) && $stable(data_size_o)
            && $stable(data_cache_o))
        else report_mismatch("request changed while waiting");
    count_check: assert property (@(posedge clk) disable iff (!resetn)
        load_wait_cnt_o == exp_load_wait && store_wait_cnt_o == exp_store_wait)
        else report_mismatch($sformatf("wait counts %0d/%0d", $sampled(load_wait_cnt_o),
            $sampled(store_wait_cnt_o)));

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state ^ (rng_state >> 15);
    endfunction

    function automatic logic [3:0] lane_strobe(input mem_op_e op, input logic [1:0] b);
        logic [3:0] s;
        int k;
        s = 4'b0000;
        for (k = 0; k < 4; k++) begin
            case (op)
                SB: s[k] = k == b;
                SH: s[k] = k == b || k == b + 1;
                SW: s[k] = 1'b1;
                SWL: s[k] = k <= b;
                SWR: s[k] = k >= b;
                default: s[k] = 1'b0;
            endcase
        end
        return s;
    endfunction

    function automatic logic [31:0] lane_data(input mem_op_e op, input logic [1:0] b,
                                              input logic [31:0] w);
        logic [31:0] d;
        int k;
        d = '0;
        for (k = 0; k < 4; k++) begin
            case (op)
                SB: d[8*k +: 8] = w[7:0];
                SH: d[8*k +: 8] = w[8*(k%2) +: 8];
                SW: d[8*k +: 8] = w[8*k +: 8];
                // swl fills lanes up to the address, swr from it
                SWL: if (k <= b) d[8*k +: 8] = w[8*(k+3-b) +: 8];
                SWR: if (k >= b) d[8*k +: 8] = w[8*(k-b) +: 8];
                default: ;
            endcase
        end
        return d;
    endfunction

    function automatic logic [2:0] size_of(input mem_op_e op);
        case (op)
            SB, LB, LBU: return SIZE_BYTE;
            SH, LH, LHU: return SIZE_HALF;
            default:     return SIZE_WORD;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue_request(input logic store);
        int waits;
        waits = next_rand() % 4;
        exp_req = 1'b1;
        data_addr_ok_i = 1'b0;
        repeat (waits) begin
            next_cycle();
            if (store) exp_store_wait++;
            else exp_load_wait++;
        end
        data_addr_ok_i = 1'b1;
        next_cycle();
    endtask

    task automatic do_access(input mem_op_e op, input logic [31:0] base,
                             input logic [15:0] offset, input logic [31:0] wdata,
                             input logic user);
        logic [31:0] ea;
        logic [19:0] vpn;
        logic        store;
        logic        err;
        logic        fault;
        ea    = base + {{16{offset[15]}}, offset};
        vpn   = ea[31:12];
        store = op inside {SB, SH, SW, SWL, SWR};
        err   = (user && ea[31]) || ((op == LW || op == SW) && ea[1:0] != 2'd0)
             || (op inside {LH, LHU, SH} && ea[0]);
        op_i = op;
        base_i = base;
        offset_i = offset;
        wdata_i = wdata;
        user_mode_i = user;
        valid_i = 1'b1;
        exp_eaddr = ea;
        exp_wr = store;
        exp_wstrb = lane_strobe(op, ea[1:0]);
        exp_wdata = lane_data(op, ea[1:0], wdata);
        exp_size = size_of(op);
        if (err) begin
            exp_exc = 1'b1;
            exp_code = store ? EXC_ADES : EXC_ADEL;
            exp_refill = 1'b0;
            next_cycle();
        end else if (ea[31:30] == 2'b10) begin
            exp_addr = {3'b000, ea[28:0]};
            exp_cache = !ea[29] && config_k0_i[0];
            issue_request(store);
        end else begin
            exp_addr = {vpn ^ PPN_XOR, ea[11:0]};
            exp_cache = 1'b1;
            fault = vpn[3:0] inside {4'hF, 4'hE} || (vpn[3:0] == 4'hD && store);
            exp_code = vpn[3:0] == 4'hD ? EXC_MOD : (store ? EXC_TLBS : EXC_TLBL);
            exp_refill = vpn[3:0] == 4'hF;
            if (!(xc_valid && xc_vpn == vpn)) begin
                next_cycle();
                exp_query = 1'b1;
                next_cycle();
                exp_query = 1'b0;
                xc_valid = 1'b1;
                xc_vpn = vpn;
            end
            if (fault) begin
                exp_exc = 1'b1;
                next_cycle();
            end else begin
                issue_request(store);
            end
        end
        valid_i = 1'b0;
        data_addr_ok_i = 1'b0;
        exp_req = 1'b0;
        exp_exc = 1'b0;
    endtask

    task automatic flush_tlb();
        tlb_flush_i = 1'b1;
        next_cycle();
        tlb_flush_i = 1'b0;
        xc_valid = 1'b0;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %-16s %0d errors", name, err_count - err_mark);
        err_mark = err_count;
        next_cycle();
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [19:0] vpn;
        mem_op_e     store_ops[5];
        int          i;
        store_ops = '{SB, SH, SW, SWL, SWR};
        rng_state = 32'd58;
        {valid_i, user_mode_i, tlb_flush_i, data_addr_ok_i} = '0;
        op_i = MEM_NONE;
        {base_i, wdata_i, offset_i, config_k0_i} = '0;
        {exp_req, exp_exc, exp_query, exp_wr, exp_cache, exp_refill} = '0;
        {exp_addr, exp_eaddr, exp_wdata, exp_wstrb, exp_size, exp_code} = '0;
        {exp_load_wait, exp_store_wait, err_count, err_mark, test_count} = '0;
        xc_valid = 1'b0;
        xc_vpn = '0;
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        #1 resetn = 1'b1;

        config_k0_i = 3'd3;
        do_access(LW, 32'h8000_1000, 16'h0010, 32'h0, 1'b0);
        do_access(SW, 32'h8000_2000, 16'h0104, 32'h1234_5678, 1'b0);
        config_k0_i = 3'd2;
        do_access(LB, 32'h8000_3000, 16'h0003, 32'h0, 1'b0);
        do_access(LH, 32'hA000_4000, 16'h0022, 32'h0, 1'b0);
        do_access(SB, 32'hA000_0100, 16'h0001, 32'h0000_00C3, 1'b0);
        // negative offset crosses below the base page
        do_access(LW, 32'h8000_5000, 16'hFFF0, 32'h0, 1'b0);
        end_test("unmapped");

        for (i = 0; i < 20; i++) begin
            r = next_rand();
            op_i = store_ops[r[31:24] % 5];
            case (op_i)
                SW: r[1:0] = 2'b00;
                SH: r[0] = 1'b0;
                default: ;
            endcase
            do_access(op_i, r[4] ? 32'hA000_0000 : 32'h8000_0000, {4'h0, r[11:0]},
                      next_rand(), 1'b0);
        end
        end_test("store_format");

        do_access(LW, 32'h8000_1001, 16'h0000, 32'h0, 1'b0);
        do_access(LH, 32'h8000_1003, 16'h0000, 32'h0, 1'b0);
        do_access(SW, 32'hA000_0002, 16'h0000, 32'h0, 1'b0);
        do_access(SH, 32'hA000_0003, 16'h0000, 32'h0, 1'b0);
        do_access(LW, 32'h8000_0100, 16'h0000, 32'h0, 1'b1);
        do_access(SB, 32'hA000_0005, 16'h0000, 32'h0, 1'b1);
        end_test("address_error");

        flush_tlb();
        do_access(LW, 32'h0040_1000, 16'h0010, 32'h0, 1'b0);
        do_access(SW, 32'h0040_1000, 16'h0020, 32'hCAFE_F00D, 1'b0);
        flush_tlb();
        do_access(LW, 32'h0040_1000, 16'h0030, 32'h0, 1'b0);
        end_test("miss_then_hit");

        do_access(LW, 32'h0040_F000, 16'h0004, 32'h0, 1'b0);
        do_access(SW, 32'h0040_F000, 16'h0008, 32'h0, 1'b0);
        do_access(LB, 32'h0041_E000, 16'h0001, 32'h0, 1'b0);
        do_access(SH, 32'h0041_E000, 16'h0002, 32'h0, 1'b0);
        do_access(SW, 32'h0042_D000, 16'h0010, 32'h0, 1'b0);
        do_access(LW, 32'h0042_D000, 16'h0014, 32'h0, 1'b0);
        do_access(SB, 32'h0042_D000, 16'h0003, 32'h0, 1'b0);
        end_test("tlb_exception");

        // few pages so that hits and misses mix
        for (i = 0; i < 30; i++) begin
            r = next_rand();
            vpn = {14'h0040, r[25:24], 4'(r[23:20] % 13)};
            if (r[5]) begin
                do_access(r[6] ? SW : LW, r[7] ? 32'hA000_0000 : 32'h8000_0000,
                          {4'h0, r[19:10], 2'b00}, next_rand(), 1'b0);
            end else begin
                do_access(r[6] ? SW : LW, {vpn, 12'h000}, {4'h0, r[19:10], 2'b00},
                          next_rand(), 1'b0);
            end
        end
        end_test("wait_counters");

        $display("%0d tests run, %0d checks failed", test_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/mem_exec_pkg.sv
rtl/xlat_if.sv
rtl/mem_addr_gen.sv
rtl/tlb_query_fsm.sv
rtl/xlat_cache.sv
rtl/mem_req_ctrl.sv
rtl/wait_cycle_counter.sv
rtl/mem_exec_top.sv
tests/mem_exec_tb.sv
